// ==== verilog/issue_pkg.sv ====
package issue_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 12;
    localparam int MEM_TYPE_W = 3;
    localparam int ECODE_W    = 7;
    localparam int CLASS_W    = 10;

    //////////////////////////////////////////////////////////////////////
    // One-hot instruction classes
    //////////////////////////////////////////////////////////////////////

    localparam logic [CLASS_W-1:0] CLASS_ALU  = 10'h001;
    localparam logic [CLASS_W-1:0] CLASS_MUL  = 10'h004;
    localparam logic [CLASS_W-1:0] CLASS_DIV  = 10'h008;
    localparam logic [CLASS_W-1:0] CLASS_ERTN = 10'h020;

    localparam logic [XLEN-1:0] PC_STEP = 32'd4;    // Sequential fetch step

    //////////////////////////////////////////////////////////////////////
    // Issue slot as read out of the issue buffer and register file
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_pre;      // Predicted next PC
        logic [CLASS_W-1:0]    inst_class;
        logic [ALU_OP_W-1:0]   alu_op;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        logic                  mem_we;
        logic [MEM_TYPE_W-1:0] mem_type;
        logic [ECODE_W-1:0]    ecode;
        logic                  ecode_we;
        logic                  sign_bit;    // Signed mul/div
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
    } issue_slot_t;

    //////////////////////////////////////////////////////////////////////
    // Execute lane
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_next;
        logic                  br_pd;       // Predicted taken
        logic [ALU_OP_W-1:0]   alu_op;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        logic                  mem_we;
        logic [MEM_TYPE_W-1:0] mem_type;
        logic [ECODE_W-1:0]    ecode;
        logic                  ecode_we;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
    } ex_lane_t;

    // Lane B special units only
    typedef struct packed {
        logic mul_en;
        logic div_en;
        logic ertn_check;
        logic sign_bit;
    } unit_ctl_t;

endpackage

// ==== verilog/issue_lane_steer.sv ====
module issue_lane_steer (
    input  issue_pkg::issue_slot_t i_slot0,
    input  issue_pkg::issue_slot_t i_slot1,
    output issue_pkg::ex_lane_t    o_lane_a,
    output issue_pkg::ex_lane_t    o_lane_b,
    output issue_pkg::unit_ctl_t   o_unit_ctl
);

    import issue_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Per-lane build shared by both lanes
    //////////////////////////////////////////////////////////////////////

    function automatic ex_lane_t build_lane(input issue_slot_t slot);
        logic [XLEN-1:0] pc_seq;
        ex_lane_t        lane;

        pc_seq = slot.pc + PC_STEP;

        lane.valid    = slot.valid;
        lane.pc       = slot.pc;
        lane.br_pd    = (slot.pc_pre != pc_seq);            // Even when invalid
        lane.pc_next  = slot.valid ? slot.pc_pre : pc_seq;  // Invalid falls through
        lane.alu_op   = slot.alu_op;
        lane.imm      = slot.imm;
        lane.rd       = slot.rd;
        lane.src1     = slot.src1;
        lane.src2     = slot.src2;

        // Side effects only from a live slot
        lane.rf_we    = slot.rf_we & slot.valid;
        lane.mem_we   = slot.mem_we & slot.valid;
        lane.mem_type = slot.mem_type & {MEM_TYPE_W{slot.valid}};
        lane.ecode    = slot.ecode & {ECODE_W{slot.valid}};
        lane.ecode_we = slot.ecode_we & slot.valid;

        return lane;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Slot to lane mapping
    //////////////////////////////////////////////////////////////////////

    logic        swap;
    issue_slot_t slot_a;
    issue_slot_t slot_b;

    // Anything but plain ALU in slot 0 must go to lane B
    assign swap = (i_slot0.inst_class != CLASS_ALU);

    always_comb begin
        if (swap) begin
            slot_a = i_slot1;
            slot_b = i_slot0;
        end else begin
            slot_a = i_slot0;
            slot_b = i_slot1;
        end
    end

    always_comb begin
        o_lane_a = build_lane(slot_a);
        o_lane_b = build_lane(slot_b);
    end

    //////////////////////////////////////////////////////////////////////
    // Lane B unit enables
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_unit_ctl.mul_en     = slot_b.valid && (slot_b.inst_class == CLASS_MUL);
        o_unit_ctl.div_en     = slot_b.valid && (slot_b.inst_class == CLASS_DIV);
        o_unit_ctl.ertn_check = slot_b.valid && (slot_b.inst_class == CLASS_ERTN);
        o_unit_ctl.sign_bit   = slot_b.sign_bit;     // Copied as is
    end

endmodule

// ==== verilog/issue_ex_reg.sv ====
module issue_ex_reg (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  issue_pkg::ex_lane_t  i_lane_a,
    input  issue_pkg::ex_lane_t  i_lane_b,
    input  issue_pkg::unit_ctl_t i_unit_ctl,
    output issue_pkg::ex_lane_t  o_lane_a,
    output issue_pkg::ex_lane_t  o_lane_b,
    output issue_pkg::unit_ctl_t o_unit_ctl
);

    //////////////////////////////////////////////////////////////////////
    // Execute stage register
    //////////////////////////////////////////////////////////////////////

    // Reset, then flush, then stall, then load
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_lane_a   <= '0;
            o_lane_b   <= '0;
            o_unit_ctl <= '0;
        end else if (i_flush) begin
            o_lane_a   <= '0;           // Bubble wins over stall
            o_lane_b   <= '0;
            o_unit_ctl <= '0;
        end else if (!i_stall) begin
            o_lane_a   <= i_lane_a;
            o_lane_b   <= i_lane_b;
            o_unit_ctl <= i_unit_ctl;
        end
    end

endmodule

// ==== verilog/issue_exe_top.sv ====
module issue_exe_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  issue_pkg::issue_slot_t i_slot0,
    input  issue_pkg::issue_slot_t i_slot1,
    output issue_pkg::ex_lane_t    o_lane_a,
    output issue_pkg::ex_lane_t    o_lane_b,
    output issue_pkg::unit_ctl_t   o_unit_ctl
);

    import issue_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Steered lanes before the execute register
    //////////////////////////////////////////////////////////////////////

    ex_lane_t  steer_lane_a;
    ex_lane_t  steer_lane_b;
    unit_ctl_t steer_unit_ctl;

    issue_lane_steer issue_lane_steer_inst (
        .i_slot0    (i_slot0),
        .i_slot1    (i_slot1),
        .o_lane_a   (steer_lane_a),
        .o_lane_b   (steer_lane_b),
        .o_unit_ctl (steer_unit_ctl)
    );

    //////////////////////////////////////////////////////////////////////
    // One-cycle execute register
    //////////////////////////////////////////////////////////////////////

    issue_ex_reg issue_ex_reg_inst (
        .clk        (clk),
        .rstn       (rstn),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_lane_a   (steer_lane_a),
        .i_lane_b   (steer_lane_b),
        .i_unit_ctl (steer_unit_ctl),
        .o_lane_a   (o_lane_a),
        .o_lane_b   (o_lane_b),
        .o_unit_ctl (o_unit_ctl)
    );

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ns;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;     // 100 ns period
    end

    initial begin
        rstn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;                        // Released on a rising edge
    end

endmodule

// ==== sim/issue_exe_checker.sv ====
module issue_exe_checker (
    input  logic                   clk,
    input  logic                   rstn,
    input  issue_pkg::issue_slot_t i_slot0,
    input  issue_pkg::issue_slot_t i_slot1,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  issue_pkg::ex_lane_t    i_lane_a,
    input  issue_pkg::ex_lane_t    i_lane_b,
    input  issue_pkg::unit_ctl_t   i_unit_ctl,
    input  logic                   i_check_en,
    input  int                     i_row_idx,
    input  logic                   i_exp_swap,
    input  logic [2:0]             i_exp_units,
    output int                     o_tests_done,
    output int                     o_fail_count
);

    timeunit 1ns;
    timeprecision 1ns;

    import issue_pkg::*;

    ex_lane_t  exp_a;
    ex_lane_t  exp_b;
    unit_ctl_t exp_ctl;
    logic      pending;
    int        pend_row;

    // Expected lane for one slot
    function automatic ex_lane_t expect_lane(input issue_slot_t s);
        ex_lane_t        l;
        logic [XLEN-1:0] seq_pc;

        seq_pc   = s.pc + 32'd4;
        l        = '0;
        l.valid  = s.valid;
        l.pc     = s.pc;
        l.br_pd  = (s.pc_pre != seq_pc);
        l.alu_op = s.alu_op;
        l.imm    = s.imm;
        l.rd     = s.rd;
        l.src1   = s.src1;
        l.src2   = s.src2;
        if (s.valid) begin
            l.pc_next  = s.pc_pre;
            l.rf_we    = s.rf_we;
            l.mem_we   = s.mem_we;
            l.mem_type = s.mem_type;
            l.ecode    = s.ecode;
            l.ecode_we = s.ecode_we;
        end else begin
            l.pc_next  = seq_pc;          // Side effects stay zero
        end
        return l;
    endfunction

    task automatic compare_outputs;
        int    bad;
        string tag;

        bad = 0;
        tag = (pend_row < 0) ? "reset" : $sformatf("row %0d", pend_row);
        if (i_lane_a !== exp_a) begin
            $display("[FAIL] %s o_lane_a expected %h got %h", tag, exp_a, i_lane_a);
            bad++;
        end
        if (i_lane_b !== exp_b) begin
            $display("[FAIL] %s o_lane_b expected %h got %h", tag, exp_b, i_lane_b);
            bad++;
        end
        if (i_unit_ctl !== exp_ctl) begin
            $display("[FAIL] %s o_unit_ctl expected %h got %h", tag, exp_ctl, i_unit_ctl);
            bad++;
        end
        o_tests_done++;
        if (bad == 0) begin
            $display("%s: pass", tag);
        end else begin
            $display("%s: fail, %0d mismatches", tag, bad);
            o_fail_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sample on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        issue_slot_t to_a;
        issue_slot_t to_b;

        if (!rstn) begin
            exp_a        = '0;
            exp_b        = '0;
            exp_ctl      = '0;
            pending      = 1'b1;          // Bubble check once reset lifts
            pend_row     = -1;
            o_tests_done = 0;
            o_fail_count = 0;
        end else begin
            if (pending) begin
                compare_outputs();
            end
            pending = i_check_en;
            if (i_check_en) begin
                pend_row = i_row_idx;
                if (i_flush) begin
                    exp_a   = '0;
                    exp_b   = '0;
                    exp_ctl = '0;
                end else if (!i_stall) begin
                    to_a               = i_exp_swap ? i_slot1 : i_slot0;
                    to_b               = i_exp_swap ? i_slot0 : i_slot1;
                    exp_a              = expect_lane(to_a);
                    exp_b              = expect_lane(to_b);
                    exp_ctl.mul_en     = i_exp_units[2];
                    exp_ctl.div_en     = i_exp_units[1];
                    exp_ctl.ertn_check = i_exp_units[0];
                    exp_ctl.sign_bit   = to_b.sign_bit;
                end                       // Stall keeps the last pair
            end
        end
    end

endmodule

// ==== sim/issue_exe_properties.sv ====
module issue_exe_properties (
    input logic                 clk,
    input logic                 rstn,
    input logic                 i_stall,
    input logic                 i_flush,
    input issue_pkg::ex_lane_t  i_lane_a,
    input issue_pkg::ex_lane_t  i_lane_b,
    input issue_pkg::unit_ctl_t i_unit_ctl
);

    timeunit 1ns;
    timeprecision 1ns;

    flush_bubble: assert property (@(posedge clk) disable iff (!rstn)
        i_flush |=> (!i_lane_a.valid && !i_lane_b.valid))
        else $error("flush left a valid lane behind");

    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (i_stall && !i_flush) |=>
            ($stable(i_lane_a) && $stable(i_lane_b) && $stable(i_unit_ctl)))
        else $error("execute register changed during stall");

    // Cycle after a reset edge must be quiet
    reset_quiet: assert property (@(posedge clk)
        !rstn |=> !(i_lane_a.rf_we || i_lane_a.mem_we || i_lane_a.ecode_we ||
                    i_lane_b.rf_we || i_lane_b.mem_we || i_lane_b.ecode_we ||
                    i_unit_ctl.mul_en || i_unit_ctl.div_en || i_unit_ctl.ertn_check))
        else $error("enable active right after reset");

endmodule

// ==== sim/issue_exe_tb.sv ====
module issue_exe_tb;

    timeunit 1ns;
    timeprecision 1ns;

    import issue_pkg::*;

    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        issue_slot_t slot0;
        issue_slot_t slot1;
        logic        stall;
        logic        flush;
        logic        swap;
        logic [2:0]  units;              // mul, div, ertn
    } row_t;

    logic        clk;
    logic        rstn;
    issue_slot_t slot0;
    issue_slot_t slot1;
    logic        stall;
    logic        flush;
    ex_lane_t    lane_a;
    ex_lane_t    lane_b;
    unit_ctl_t   unit_ctl;
    logic        check_en;
    int          row_idx;
    logic        exp_swap;
    logic [2:0]  exp_units;
    int          tests_done;
    int          fail_count;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    row_t        rows[$];

    tb_clock tb_clock_inst (
        .clk  (clk),
        .rstn (rstn)
    );

    issue_exe_top issue_exe_top_inst (
        .clk        (clk),
        .rstn       (rstn),
        .i_stall    (stall),
        .i_flush    (flush),
        .i_slot0    (slot0),
        .i_slot1    (slot1),
        .o_lane_a   (lane_a),
        .o_lane_b   (lane_b),
        .o_unit_ctl (unit_ctl)
    );

    issue_exe_checker issue_exe_checker_inst (
        .clk          (clk),
        .rstn         (rstn),
        .i_slot0      (slot0),
        .i_slot1      (slot1),
        .i_stall      (stall),
        .i_flush      (flush),
        .i_lane_a     (lane_a),
        .i_lane_b     (lane_b),
        .i_unit_ctl   (unit_ctl),
        .i_check_en   (check_en),
        .i_row_idx    (row_idx),
        .i_exp_swap   (exp_swap),
        .i_exp_units  (exp_units),
        .o_tests_done (tests_done),
        .o_fail_count (fail_count)
    );

    bind issue_ex_reg issue_exe_properties issue_exe_properties_inst (
        .clk        (clk),
        .rstn       (rstn),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_lane_a   (o_lane_a),
        .i_lane_b   (o_lane_b),
        .i_unit_ctl (o_unit_ctl)
    );

    function automatic issue_slot_t make_slot(input logic v, input logic [CLASS_W-1:0] cls);
        issue_slot_t s;
        logic [31:0] r;

        r            = $urandom();
        s.pc         = {r[31:2], 2'b00};
        r            = $urandom();
        s.pc_pre     = r[0] ? {r[31:2], 2'b00} : s.pc + 32'd4;   // Taken about half the time
        s.valid      = v;
        s.inst_class = cls;
        r            = $urandom();
        s.alu_op     = r[11:0];
        s.rd         = r[16:12];
        s.rf_we      = r[17];
        s.mem_we     = r[18];
        s.mem_type   = r[21:19];
        s.ecode      = r[28:22];
        s.ecode_we   = r[29];
        s.sign_bit   = r[30];
        s.imm        = $urandom();
        s.src1       = $urandom();
        s.src2       = $urandom();
        if (!v) begin
            s.rf_we    = 1'b1;              // Something to mask
            s.mem_we   = 1'b1;
            s.mem_type = 3'b111;
            s.ecode    = 7'h7f;
            s.ecode_we = 1'b1;
        end
        return s;
    endfunction

    task automatic add_row(input logic v0, input logic [CLASS_W-1:0] c0,
                           input logic v1, input logic [CLASS_W-1:0] c1,
                           input logic st, input logic fl,
                           input logic sw, input logic [2:0] units);
        row_t r;

        r.slot0 = make_slot(v0, c0);
        r.slot1 = make_slot(v1, c1);
        r.stall = st;
        r.flush = fl;
        r.swap  = sw;
        r.units = units;
        rows.push_back(r);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, checker never finished", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus table and row loop
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h4ce6));
        slot0     <= '0;
        slot1     <= '0;
        stall     <= 1'b0;
        flush     <= 1'b0;
        check_en  <= 1'b0;
        row_idx   <= 0;
        exp_swap  <= 1'b0;
        exp_units <= 3'b000;

        //       v0    class0      v1    class1      stall flush swap  mul/div/ertn
        add_row(1'b1, CLASS_ALU,  1'b1, CLASS_ALU,  1'b0, 1'b0, 1'b0, 3'b000);
        add_row(1'b1, CLASS_ALU,  1'b1, CLASS_MUL,  1'b0, 1'b0, 1'b0, 3'b100);
        add_row(1'b1, CLASS_MUL,  1'b1, CLASS_ALU,  1'b0, 1'b0, 1'b1, 3'b100);
        add_row(1'b1, CLASS_DIV,  1'b1, CLASS_ALU,  1'b0, 1'b0, 1'b1, 3'b010);
        add_row(1'b1, CLASS_ERTN, 1'b0, CLASS_ALU,  1'b0, 1'b0, 1'b1, 3'b001);
        add_row(1'b0, CLASS_MUL,  1'b1, CLASS_ALU,  1'b0, 1'b0, 1'b1, 3'b000);
        add_row(1'b1, CLASS_ALU,  1'b0, CLASS_ALU,  1'b0, 1'b0, 1'b0, 3'b000);
        add_row(1'b0, CLASS_ALU,  1'b0, CLASS_ALU,  1'b0, 1'b0, 1'b0, 3'b000);
        add_row(1'b1, CLASS_ERTN, 1'b1, CLASS_MUL,  1'b0, 1'b0, 1'b1, 3'b001);
        add_row(1'b1, CLASS_DIV,  1'b1, CLASS_ALU,  1'b1, 1'b0, 1'b1, 3'b010);
        add_row(1'b1, CLASS_ALU,  1'b1, CLASS_MUL,  1'b1, 1'b0, 1'b0, 3'b100);
        add_row(1'b1, CLASS_MUL,  1'b1, CLASS_ALU,  1'b1, 1'b0, 1'b1, 3'b100);
        add_row(1'b1, CLASS_DIV,  1'b1, CLASS_ALU,  1'b0, 1'b0, 1'b1, 3'b010);
        add_row(1'b1, CLASS_MUL,  1'b1, CLASS_ALU,  1'b0, 1'b1, 1'b1, 3'b100);
        add_row(1'b1, CLASS_ALU,  1'b1, CLASS_DIV,  1'b0, 1'b0, 1'b0, 3'b010);
        add_row(1'b1, CLASS_ALU,  1'b1, CLASS_ALU,  1'b1, 1'b0, 1'b0, 3'b000);
        add_row(1'b1, CLASS_MUL,  1'b1, CLASS_ALU,  1'b1, 1'b1, 1'b1, 3'b100);
        add_row(1'b1, CLASS_ALU,  1'b1, CLASS_ERTN, 1'b0, 1'b0, 1'b0, 3'b001);
        add_row(1'b0, CLASS_DIV,  1'b1, CLASS_DIV,  1'b0, 1'b0, 1'b1, 3'b000);
        cycle_limit = RESET_CYCLES + rows.size() + 20;

        @(posedge clk);
        while (!rstn) @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            slot0     <= rows[i].slot0;
            slot1     <= rows[i].slot1;
            stall     <= rows[i].stall;
            flush     <= rows[i].flush;
            check_en  <= 1'b1;
            row_idx   <= i;
            exp_swap  <= rows[i].swap;
            exp_units <= rows[i].units;
            @(posedge clk);
        end
        check_en <= 1'b0;
        stall    <= 1'b0;
        flush    <= 1'b0;

        wait (tests_done == rows.size() + 1);     // Rows plus the reset check
        $display("Summary: %0d tests, %0d passed, %0d failed",
                 tests_done, tests_done - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/issue_pkg.sv
verilog/issue_lane_steer.sv
verilog/issue_ex_reg.sv
verilog/issue_exe_top.sv
sim/tb_clock.sv
sim/issue_exe_checker.sv
sim/issue_exe_properties.sv
sim/issue_exe_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns \
    -f all.f --top-module issue_exe_tb -o issue_exe_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/issue_exe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
